// ==== Makefile ====
# Verilator flow for the front end testbench

VERILATOR  ?= verilator
TOP        := tb_frontend_top
FILELIST   := dmm_frontend.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --top-module $(TOP)
SIM_FLAGS  := --binary --assert --timing --top-module $(TOP) --Mdir $(BUILD_DIR)
# keep running past an assertion error so the closing summary is printed
SIM_ARGS   := +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dmm_frontend.f ====
+incdir+rtl
rtl/spi_pkg.sv
rtl/frontend_pkg.sv
rtl/spi_register_bank.sv
rtl/test_pattern_gen.sv
rtl/conditioning_mux.sv
rtl/spi_port_router.sv
rtl/frontend_top.sv
tb/frontend_props.sv
tb/tb_frontend_top.sv

// ==== rtl/conditioning_mux.sv ====
`timescale 1ns/1ps
/*
  conditioning output select by mode register
  off, count pattern, walking one or direct register, registered
*/
`include "frontend_config.svh"

module conditioning_mux (
  input  logic                     clk,
  input  logic                     rst_n,
  input  spi_pkg::reg_word_t       reg_mode,
  input  spi_pkg::reg_word_t       reg_direct,
  input  frontend_pkg::cond_word_t count_pattern,
  input  frontend_pkg::cond_word_t walk_pattern,
  output frontend_pkg::monitor_t   monitor,
  output logic                     led,
  output logic                     pc_sw_ctl,
  output frontend_pkg::mux_ctl_t   himux_ctl,
  output frontend_pkg::mux_ctl_t   azmux_ctl
);

  frontend_pkg::cond_mode_t mode;
  frontend_pkg::cond_word_t cond_next;
  frontend_pkg::cond_word_t cond_q;

  // only the bottom two mode bits mean anything
  assign mode = frontend_pkg::cond_mode_t'(reg_mode[1:0]);

  always_comb
  begin
    case (mode)
      frontend_pkg::MODE_COUNT:  cond_next = count_pattern;
      frontend_pkg::MODE_WALK:   cond_next = walk_pattern;
      frontend_pkg::MODE_DIRECT: cond_next = reg_direct[`FE_COND_BITS-1:0];
      default:                   cond_next = '0;
    endcase
  end

  // one register stage keeps the switch pins glitch free
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      cond_q <= '0;
    else
      cond_q <= cond_next;
  end

  ////////////////////////////////////////////////////////////
  // split into pin groups

  // msb first: monitor, led, precharge, himux, azmux
  assign {monitor, led, pc_sw_ctl, himux_ctl, azmux_ctl} = cond_q;

endmodule

// ==== rtl/frontend_config.svh ====
/*
  widths, register addresses, pattern prescaler
  and 4094 strobe polarity for the analog front end
*/
`ifndef FRONTEND_CONFIG_SVH
`define FRONTEND_CONFIG_SVH

// datapath widths
`define FE_COND_BITS    18
`define FE_REG_BITS     24
`define FE_ADDR_BITS    8

// clk cycles per test pattern step
`define FE_PATTERN_DIV  16

// one bit per chain line, set means strobe is high while selected
`define FE_4094_CS_POL  8'b0000_0001

// register map
`define FE_ADDR_LED     8'h07
`define FE_ADDR_SPI_MUX 8'h08
`define FE_ADDR_4094    8'h09
`define FE_ADDR_MODE    8'h0A
`define FE_ADDR_DIRECT  8'h0B

`endif

// ==== rtl/frontend_pkg.sv ====
/*
  analog side types
  conditioning word, mux control nibble, monitor byte, mode codes
*/
`include "frontend_config.svh"

package frontend_pkg;

  // msb down: monitor[7:0], led, pc_sw, himux[3:0], azmux[3:0]
  typedef logic [`FE_COND_BITS-1:0] cond_word_t;

  // en, a2, a1, a0
  typedef logic [3:0] mux_ctl_t;

  // monitor header pins
  typedef logic [7:0] monitor_t;

  // what drives the conditioning outputs
  typedef enum logic [1:0] {
    MODE_OFF    = 2'd0,
    MODE_COUNT  = 2'd1,
    MODE_WALK   = 2'd2,
    MODE_DIRECT = 2'd3
  } cond_mode_t;

endpackage

// ==== rtl/frontend_top.sv ====
`timescale 1ns/1ps
/*
  analog front end control top
  register bank, pattern generator, conditioning mux, spi router
*/

module frontend_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   spi_clk,
  input  logic                   spi_cs,
  input  logic                   spi_cs2,
  input  logic                   spi_mosi,
  input  logic                   u1004_data,
  output logic                   spi_miso,
  output logic                   glb_4094_clk,
  output logic                   glb_4094_data,
  output logic                   glb_4094_strobe,
  output logic                   oe_4094,
  output frontend_pkg::monitor_t monitor,
  output logic                   led,
  output logic                   pc_sw_ctl,
  output frontend_pkg::mux_ctl_t himux_ctl,
  output frontend_pkg::mux_ctl_t azmux_ctl
);

  logic                     rd_data;
  spi_pkg::reg_word_t       reg_led;
  spi_pkg::reg_word_t       reg_spi_mux;
  spi_pkg::reg_word_t       reg_4094;
  spi_pkg::reg_word_t       reg_mode;
  spi_pkg::reg_word_t       reg_direct;
  frontend_pkg::cond_word_t count_pattern;
  frontend_pkg::cond_word_t walk_pattern;
  logic [7:0]               vec_cs;
  logic [7:0]               vec_clk;
  logic [7:0]               vec_mosi;
  logic [7:0]               vec_miso;

  // only chain line 0 is fitted on this board
  assign vec_miso        = {7'b0, u1004_data};
  assign glb_4094_clk    = vec_clk[0];
  assign glb_4094_data   = vec_mosi[0];
  assign glb_4094_strobe = vec_cs[0];

  spi_register_bank u_spi_register_bank (
    .clk         (clk),
    .rst_n       (rst_n),
    .spi_clk     (spi_clk),
    .spi_cs      (spi_cs),
    .spi_mosi    (spi_mosi),
    .rd_data     (rd_data),
    .reg_led     (reg_led),
    .reg_spi_mux (reg_spi_mux),
    .reg_4094    (reg_4094),
    .reg_mode    (reg_mode),
    .reg_direct  (reg_direct),
    .oe_4094     (oe_4094)
  );

  test_pattern_gen u_test_pattern_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .count_pattern (count_pattern),
    .walk_pattern  (walk_pattern)
  );

  conditioning_mux u_conditioning_mux (
    .clk           (clk),
    .rst_n         (rst_n),
    .reg_mode      (reg_mode),
    .reg_direct    (reg_direct),
    .count_pattern (count_pattern),
    .walk_pattern  (walk_pattern),
    .monitor       (monitor),
    .led           (led),
    .pc_sw_ctl     (pc_sw_ctl),
    .himux_ctl     (himux_ctl),
    .azmux_ctl     (azmux_ctl)
  );

  // reg_led is a scratch register, read back over spi only
  spi_port_router u_spi_port_router (
    .spi_clk     (spi_clk),
    .spi_mosi    (spi_mosi),
    .spi_cs      (spi_cs),
    .spi_cs2     (spi_cs2),
    .reg_spi_mux (reg_spi_mux),
    .rd_data     (rd_data),
    .vec_miso    (vec_miso),
    .vec_cs      (vec_cs),
    .vec_clk     (vec_clk),
    .vec_mosi    (vec_mosi),
    .spi_miso    (spi_miso)
  );

endmodule

// ==== rtl/spi_pkg.sv ====
/*
  host link types
  register word, address, frame bit count, receiver states
*/
`include "frontend_config.svh"

package spi_pkg;

  // one register as seen over spi
  typedef logic [`FE_REG_BITS-1:0] reg_word_t;

  // register address, first byte of a frame
  typedef logic [`FE_ADDR_BITS-1:0] reg_addr_t;

  // bits received so far in a frame
  // wide enough to see a frame run past 32 bits
  typedef logic [5:0] frame_count_t;

  // receiver sequence within one chip select
  typedef enum logic [1:0] {
    RX_IDLE = 2'd0,
    RX_ADDR = 2'd1,
    RX_DATA = 2'd2,
    RX_DONE = 2'd3
  } rx_state_t;

endpackage

// ==== rtl/spi_port_router.sv ====
`timescale 1ns/1ps
/*
  host spi port router
  cs2 passes the host lines to the enabled 4094 chain lines, picks miso
*/
`include "frontend_config.svh"

module spi_port_router (
  input  logic               spi_clk,
  input  logic               spi_mosi,
  input  logic               spi_cs,
  input  logic               spi_cs2,
  input  spi_pkg::reg_word_t reg_spi_mux,
  input  logic               rd_data,
  input  logic [7:0]         vec_miso,
  output logic [7:0]         vec_cs,
  output logic [7:0]         vec_clk,
  output logic [7:0]         vec_mosi,
  output logic               spi_miso
);

  localparam logic [7:0] CS_POL = `FE_4094_CS_POL;

  // lines that are both enabled and currently selected
  logic [7:0] line_sel;

  assign line_sel = reg_spi_mux[7:0] & {8{~spi_cs2}};

  ////////////////////////////////////////////////////////////
  // chain lines

  // idle lines sit low
  assign vec_clk  = line_sel & {8{spi_clk}};
  assign vec_mosi = line_sel & {8{spi_mosi}};

  // selected gives the polarity level, unselected its inverse
  assign vec_cs = ~(CS_POL ^ line_sel);

  ////////////////////////////////////////////////////////////
  // miso source

  always_comb
  begin
    if (!spi_cs)
      spi_miso = rd_data;
    else if (!spi_cs2)
      spi_miso = |(vec_miso & reg_spi_mux[7:0]);
    else
      spi_miso = 1'b0;
  end

endmodule

// ==== rtl/spi_register_bank.sv ====
`timescale 1ns/1ps
/*
  spi slave sampled on clk: pin synchronizers, edge detect,
  address/data receiver, five control registers, read data shifter
*/
`include "frontend_config.svh"

module spi_register_bank (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               spi_clk,
  input  logic               spi_cs,
  input  logic               spi_mosi,
  output logic               rd_data,
  output spi_pkg::reg_word_t reg_led,
  output spi_pkg::reg_word_t reg_spi_mux,
  output spi_pkg::reg_word_t reg_4094,
  output spi_pkg::reg_word_t reg_mode,
  output spi_pkg::reg_word_t reg_direct,
  output logic               oe_4094
);

  localparam spi_pkg::frame_count_t ADDR_LAST =
    spi_pkg::frame_count_t'(`FE_ADDR_BITS - 1);
  localparam spi_pkg::frame_count_t FRAME_BITS =
    spi_pkg::frame_count_t'(`FE_ADDR_BITS + `FE_REG_BITS);

  // [0] and [1] synchronize, [2] is the previous level
  logic [2:0] clk_sr;
  logic [2:0] cs_sr;
  logic [2:0] mosi_sr;

  // registered edge pulses
  logic clk_rise_q;
  logic clk_fall_q;
  logic cs_fall_q;
  logic cs_rise_q;

  spi_pkg::rx_state_t    state;
  spi_pkg::frame_count_t bit_cnt;
  spi_pkg::reg_addr_t    addr_q;
  spi_pkg::reg_addr_t    addr_next;
  spi_pkg::reg_word_t    rx_word;
  spi_pkg::reg_word_t    tx_word;
  spi_pkg::reg_word_t    rd_lookup;
  logic                  frame_ok;

  ////////////////////////////////////////////////////////////
  // pin sync and edge detect

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      clk_sr     <= '0;
      cs_sr      <= '1;
      mosi_sr    <= '0;
      clk_rise_q <= 1'b0;
      clk_fall_q <= 1'b0;
      cs_fall_q  <= 1'b0;
      cs_rise_q  <= 1'b0;
    end
    else
    begin
      clk_sr     <= {clk_sr[1:0], spi_clk};
      cs_sr      <= {cs_sr[1:0], spi_cs};
      mosi_sr    <= {mosi_sr[1:0], spi_mosi};
      clk_rise_q <= clk_sr[1] & ~clk_sr[2];
      clk_fall_q <= ~clk_sr[1] & clk_sr[2];
      cs_fall_q  <= ~cs_sr[1] & cs_sr[2];
      cs_rise_q  <= cs_sr[1] & ~cs_sr[2];
    end
  end

  ////////////////////////////////////////////////////////////
  // receiver fsm

  // mosi_sr[2] lines up with the rise pulse
  assign addr_next = {addr_q[`FE_ADDR_BITS-2:0], mosi_sr[2]};

  // exactly 32 bits seen before cs went high
  assign frame_ok = (state == spi_pkg::RX_DONE) && (bit_cnt == FRAME_BITS);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state   <= spi_pkg::RX_IDLE;
      bit_cnt <= '0;
    end
    else if (cs_rise_q)
      state <= spi_pkg::RX_IDLE;
    else
    begin
      case (state)
        spi_pkg::RX_IDLE:
          if (cs_fall_q)
          begin
            state   <= spi_pkg::RX_ADDR;
            bit_cnt <= '0;
          end
        spi_pkg::RX_ADDR:
          if (clk_rise_q)
          begin
            bit_cnt <= bit_cnt + 6'd1;
            if (bit_cnt == ADDR_LAST)
              state <= spi_pkg::RX_DATA;
          end
        spi_pkg::RX_DATA:
          if (clk_rise_q)
          begin
            bit_cnt <= bit_cnt + 6'd1;
            if (bit_cnt == FRAME_BITS - 6'd1)
              state <= spi_pkg::RX_DONE;
          end
        default:
          // extra clocks past 32 spoil the frame
          if (clk_rise_q && bit_cnt != '1)
            bit_cnt <= bit_cnt + 6'd1;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // shift registers

  always_comb
  begin
    case (addr_next)
      `FE_ADDR_LED:     rd_lookup = reg_led;
      `FE_ADDR_SPI_MUX: rd_lookup = reg_spi_mux;
      `FE_ADDR_4094:    rd_lookup = reg_4094;
      `FE_ADDR_MODE:    rd_lookup = reg_mode;
      `FE_ADDR_DIRECT:  rd_lookup = reg_direct;
      default:          rd_lookup = '0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (clk_rise_q && state == spi_pkg::RX_ADDR)
      addr_q <= addr_next;
    if (clk_rise_q && state == spi_pkg::RX_DATA)
      rx_word <= {rx_word[`FE_REG_BITS-2:0], mosi_sr[2]};
    // msb sits on miso before the first data rise, so no shift after the address
    if (cs_fall_q)
      tx_word <= '0;
    else if (clk_rise_q && state == spi_pkg::RX_ADDR && bit_cnt == ADDR_LAST)
      tx_word <= rd_lookup;
    else if (clk_fall_q && state == spi_pkg::RX_DATA && bit_cnt != ADDR_LAST + 6'd1)
      tx_word <= {tx_word[`FE_REG_BITS-2:0], 1'b0};
  end

  assign rd_data = tx_word[`FE_REG_BITS-1];

  ////////////////////////////////////////////////////////////
  // register file

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      reg_led     <= '0;
      reg_spi_mux <= '0;
      reg_4094    <= '0;
      reg_mode    <= '0;
      reg_direct  <= '0;
    end
    else if (cs_rise_q && frame_ok)
    begin
      case (addr_q)
        `FE_ADDR_LED:     reg_led     <= rx_word;
        `FE_ADDR_SPI_MUX: reg_spi_mux <= rx_word;
        `FE_ADDR_4094:    reg_4094    <= rx_word;
        `FE_ADDR_MODE:    reg_mode    <= rx_word;
        `FE_ADDR_DIRECT:  reg_direct  <= rx_word;
        default:          ;
      endcase
    end
  end

  // 4094 output enable
  assign oe_4094 = reg_4094[0];

endmodule

// ==== rtl/test_pattern_gen.sv ====
`timescale 1ns/1ps
/*
  test patterns for the conditioning outputs
  prescaled binary count and walking one, stepping together
*/
`include "frontend_config.svh"

module test_pattern_gen (
  input  logic                     clk,
  input  logic                     rst_n,
  output frontend_pkg::cond_word_t count_pattern,
  output frontend_pkg::cond_word_t walk_pattern
);

  localparam int unsigned PRE_BITS = $clog2(`FE_PATTERN_DIV);
  localparam logic [PRE_BITS-1:0] PRE_LAST = PRE_BITS'(`FE_PATTERN_DIV - 1);

  logic [PRE_BITS-1:0] pre_cnt;
  logic                step;

  ////////////////////////////////////////////////////////////
  // prescaler

  // one step pulse every FE_PATTERN_DIV clocks
  assign step = (pre_cnt == PRE_LAST);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      pre_cnt <= '0;
    else if (step)
      pre_cnt <= '0;
    else
      pre_cnt <= pre_cnt + 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // patterns

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      count_pattern <= '0;
      // walking one starts at bit 0
      walk_pattern  <= frontend_pkg::cond_word_t'(1);
    end
    else if (step)
    begin
      // wraps at 2**18
      count_pattern <= count_pattern + 1'b1;
      // rotate left, msb back into bit 0
      walk_pattern  <= {walk_pattern[`FE_COND_BITS-2:0], walk_pattern[`FE_COND_BITS-1]};
    end
  end

endmodule

// ==== tb/frontend_props.sv ====
`timescale 1ns/1ps
/*
  concurrent checks on the front end pins, bound into frontend_top
  reset state, count and walk steps, off mode, idle strobe
*/
`include "frontend_config.svh"

module frontend_props (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   spi_cs2,
  input  logic                   oe_4094,
  input  logic                   glb_4094_strobe,
  input  frontend_pkg::monitor_t monitor,
  input  logic                   led,
  input  logic                   pc_sw_ctl,
  input  frontend_pkg::mux_ctl_t himux_ctl,
  input  frontend_pkg::mux_ctl_t azmux_ctl,
  input  spi_pkg::reg_word_t     reg_mode
);

  // read by the testbench for its closing count
  int unsigned              fail_count = 0;
  frontend_pkg::cond_word_t cond;
  frontend_pkg::cond_word_t cond_d;
  frontend_pkg::cond_mode_t mode_d1;
  frontend_pkg::cond_mode_t mode_d2;

  // pins back in cond_word_t order
  assign cond = {monitor, led, pc_sw_ctl, himux_ctl, azmux_ctl};

  // the pins show the mode of one cycle back, cond_d the one before
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      cond_d  <= '0;
      mode_d1 <= frontend_pkg::MODE_OFF;
      mode_d2 <= frontend_pkg::MODE_OFF;
    end
    else
    begin
      cond_d  <= cond;
      mode_d1 <= frontend_pkg::cond_mode_t'(reg_mode[1:0]);
      mode_d2 <= mode_d1;
    end
  end

  ////////////////////////////////////////////////////////////
  // reset and idle

  reset_clears: assert property (@(posedge clk)
    !rst_n |=> (cond == '0 && !oe_4094 && !glb_4094_strobe))
  else
  begin
    fail_count++;
    $error("outputs not cleared by reset");
  end

  // line 0 strobe is active high
  strobe_idle: assert property (@(posedge clk) disable iff (!rst_n)
    spi_cs2 |-> !glb_4094_strobe)
  else
  begin
    fail_count++;
    $error("4094 strobe active with spi_cs2 high");
  end

  ////////////////////////////////////////////////////////////
  // modes

  off_is_zero: assert property (@(posedge clk) disable iff (!rst_n)
    mode_d1 == frontend_pkg::MODE_OFF |-> cond == '0)
  else
  begin
    fail_count++;
    $error("conditioning word not zero in off mode");
  end

  count_steps: assert property (@(posedge clk) disable iff (!rst_n)
    (mode_d1 == frontend_pkg::MODE_COUNT && mode_d2 == frontend_pkg::MODE_COUNT
     && cond != cond_d) |-> cond == frontend_pkg::cond_word_t'(cond_d + 1'b1))
  else
  begin
    fail_count++;
    $error("count pattern did not step by one");
  end

  walk_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    mode_d1 == frontend_pkg::MODE_WALK |-> $onehot(cond))
  else
  begin
    fail_count++;
    $error("walk pattern not one-hot");
  end

  walk_rotates: assert property (@(posedge clk) disable iff (!rst_n)
    (mode_d1 == frontend_pkg::MODE_WALK && mode_d2 == frontend_pkg::MODE_WALK
     && cond != cond_d)
    |-> cond == {cond_d[`FE_COND_BITS-2:0], cond_d[`FE_COND_BITS-1]})
  else
  begin
    fail_count++;
    $error("walk pattern did not rotate left");
  end

endmodule

// reg_mode is the top level's internal register wire
bind frontend_top frontend_props u_frontend_props (
  .clk             (clk),
  .rst_n           (rst_n),
  .spi_cs2         (spi_cs2),
  .oe_4094         (oe_4094),
  .glb_4094_strobe (glb_4094_strobe),
  .monitor         (monitor),
  .led             (led),
  .pc_sw_ctl       (pc_sw_ctl),
  .himux_ctl       (himux_ctl),
  .azmux_ctl       (azmux_ctl),
  .reg_mode        (reg_mode)
);

// ==== tb/tb_frontend_top.sv ====
`timescale 1ns/1ps
/*
  testbench for frontend_top
  spi frames, register readback, conditioning modes, 4094 pass-through
*/
`include "frontend_config.svh"

module tb_frontend_top;

  // ten readback frames plus nine more frames at ~270 cycles each, with margin
  localparam int unsigned MAX_CYCLES    = 6000;
  localparam int unsigned SPI_HOLD      = 4;
  // bank write 4 cycles after cs rises, mux one more
  localparam int unsigned WRITE_LATENCY = 5;

  logic                     clk;
  logic                     rst_n;
  logic                     spi_clk;
  logic                     spi_cs;
  logic                     spi_cs2;
  logic                     spi_mosi;
  logic                     u1004_data;
  logic                     spi_miso;
  logic                     glb_4094_clk;
  logic                     glb_4094_data;
  logic                     glb_4094_strobe;
  logic                     oe_4094;
  frontend_pkg::monitor_t   monitor;
  logic                     led;
  logic                     pc_sw_ctl;
  frontend_pkg::mux_ctl_t   himux_ctl;
  frontend_pkg::mux_ctl_t   azmux_ctl;
  frontend_pkg::cond_word_t cond_word;

  logic [31:0]        lfsr_state;
  int unsigned        cycle_count;
  int unsigned        pass_count;
  int unsigned        fail_count;
  spi_pkg::reg_word_t miso_word;

  assign cond_word = {monitor, led, pc_sw_ctl, himux_ctl, azmux_ctl};

  frontend_top u_frontend_top (
    .clk             (clk),
    .rst_n           (rst_n),
    .spi_clk         (spi_clk),
    .spi_cs          (spi_cs),
    .spi_cs2         (spi_cs2),
    .spi_mosi        (spi_mosi),
    .u1004_data      (u1004_data),
    .spi_miso        (spi_miso),
    .glb_4094_clk    (glb_4094_clk),
    .glb_4094_data   (glb_4094_data),
    .glb_4094_strobe (glb_4094_strobe),
    .oe_4094         (oe_4094),
    .monitor         (monitor),
    .led             (led),
    .pc_sw_ctl       (pc_sw_ctl),
    .himux_ctl       (himux_ctl),
    .azmux_ctl       (azmux_ctl)
  );

  // 10 ns period
  always #5 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES)
    begin
      $display("run stopped after %0d clock cycles without finishing", MAX_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // helpers

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit taken, newest bit lands in bit 0
  task automatic take_random(input int unsigned nbits, output logic [31:0] value);
    int unsigned i;
    value = '0;
    for (i = 0; i < nbits; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = {value[30:0], lfsr_state[0]};
    end
  endtask

  function automatic int unsigned total_failures();
    return fail_count + u_frontend_top.u_frontend_props.fail_count;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
    begin
      pass_count++;
    end
    else
    begin
      fail_count++;
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // returns 1 ns after a rising edge, where all inputs are driven
  task automatic wait_cycles(input int unsigned n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // address then data, msb first, miso captured at the end of each low phase
  task automatic spi_frame(input spi_pkg::reg_addr_t addr, input spi_pkg::reg_word_t data);
    logic [31:0] frame;
    int          i;
    frame     = {addr, data};
    miso_word = '0;
    spi_cs    = 1'b0;
    wait_cycles(SPI_HOLD);
    for (i = 31; i >= 0; i--)
    begin
      spi_clk  = 1'b0;
      spi_mosi = frame[i];
      wait_cycles(SPI_HOLD);
      if (i < 24)
        miso_word = {miso_word[22:0], spi_miso};
      spi_clk = 1'b1;
      wait_cycles(SPI_HOLD);
    end
    spi_clk = 1'b0;
    wait_cycles(SPI_HOLD);
    spi_cs = 1'b1;
  endtask

  task automatic write_reg(input spi_pkg::reg_addr_t addr, input spi_pkg::reg_word_t data);
    spi_frame(addr, data);
    wait_cycles(WRITE_LATENCY);
  endtask

  // props check each step, this only makes sure the steps happen
  task automatic wait_cond_changes(input int unsigned changes, input string what);
    frontend_pkg::cond_word_t last;
    int unsigned              seen;
    int unsigned              waited;
    last   = cond_word;
    seen   = 0;
    waited = 0;
    while (seen < changes && waited < (changes + 1) * `FE_PATTERN_DIV)
    begin
      wait_cycles(1);
      waited++;
      if (cond_word != last)
        seen++;
      last = cond_word;
    end
    assert (seen >= changes)
    else
    begin
      fail_count++;
      $display("%s: conditioning outputs stopped stepping", what);
    end
  endtask

  task automatic report_test(input string name, input int unsigned fails_before);
    int unsigned fails;
    fails = total_failures() - fails_before;
    if (fails == 0)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d failed checks", name, fails);
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence

  initial
  begin
    spi_pkg::reg_addr_t addr_list [5];
    spi_pkg::reg_word_t first_words [5];
    logic [31:0]        rnd;
    int unsigned        fails_before;
    int                 k;
    clk         = 1'b0;
    rst_n       = 1'b0;
    spi_clk     = 1'b0;
    spi_cs      = 1'b1;
    spi_cs2     = 1'b1;
    spi_mosi    = 1'b0;
    u1004_data  = 1'b0;
    lfsr_state  = 32'hf83c70d5;
    cycle_count = 0;
    pass_count  = 0;
    fail_count  = 0;
    addr_list[0] = `FE_ADDR_LED;
    addr_list[1] = `FE_ADDR_SPI_MUX;
    addr_list[2] = `FE_ADDR_4094;
    addr_list[3] = `FE_ADDR_MODE;
    addr_list[4] = `FE_ADDR_DIRECT;

    // reset state, outputs themselves are watched by props
    wait_cycles(16);
    rst_n        = 1'b1;
    fails_before = total_failures();
    wait_cycles(4);
    check_value("spi_miso", 32'(spi_miso), 32'd0);
    report_test("reset", fails_before);

    // second frame reads back what the first wrote
    fails_before = total_failures();
    for (k = 0; k < 5; k++)
    begin
      take_random(24, rnd);
      first_words[k] = rnd[23:0];
      write_reg(addr_list[k], first_words[k]);
    end
    for (k = 0; k < 5; k++)
    begin
      take_random(24, rnd);
      write_reg(addr_list[k], rnd[23:0]);
      check_value("spi_miso readback", 32'(miso_word), 32'(first_words[k]));
    end
    report_test("register readback", fails_before);

    // direct word on the pins 5 cycles after cs rises
    fails_before = total_failures();
    write_reg(`FE_ADDR_MODE, 24'h3);
    take_random(24, rnd);
    write_reg(`FE_ADDR_DIRECT, rnd[23:0]);
    check_value("cond_word", 32'(cond_word), 32'(rnd[`FE_COND_BITS-1:0]));
    report_test("direct mode", fails_before);

    fails_before = total_failures();
    write_reg(`FE_ADDR_MODE, 24'h1);
    wait_cond_changes(3, "count mode");
    report_test("count mode", fails_before);

    // walk, then off
    fails_before = total_failures();
    write_reg(`FE_ADDR_MODE, 24'h2);
    wait_cond_changes(3, "walk mode");
    check_value("cond_word set bits", 32'($countones(cond_word)), 32'd1);
    write_reg(`FE_ADDR_MODE, 24'h0);
    check_value("cond_word", 32'(cond_word), 32'd0);
    report_test("walk and off modes", fails_before);

    ////////////////////////////////////////////////////////////
    // 4094 chain line 0

    fails_before = total_failures();
    write_reg(`FE_ADDR_SPI_MUX, 24'h1);
    spi_cs2 = 1'b0;
    for (k = 0; k < 8; k++)
    begin
      spi_clk = ~spi_clk;
      take_random(1, rnd);
      spi_mosi = rnd[0];
      take_random(1, rnd);
      u1004_data = rnd[0];
      wait_cycles(1);
      check_value("glb_4094_clk", 32'(glb_4094_clk), 32'(spi_clk));
      check_value("glb_4094_data", 32'(glb_4094_data), 32'(spi_mosi));
      check_value("glb_4094_strobe", 32'(glb_4094_strobe), 32'd1);
      check_value("spi_miso", 32'(spi_miso), 32'(u1004_data));
    end
    spi_clk = 1'b0;
    spi_cs2 = 1'b1;
    wait_cycles(1);
    check_value("glb_4094_strobe", 32'(glb_4094_strobe), 32'd0);
    check_value("glb_4094_clk", 32'(glb_4094_clk), 32'd0);
    // oe follows bit 0 of the 4094 register, low first so the raise is seen
    write_reg(`FE_ADDR_4094, 24'h0);
    check_value("oe_4094", 32'(oe_4094), 32'd0);
    write_reg(`FE_ADDR_4094, 24'h1);
    check_value("oe_4094", 32'(oe_4094), 32'd1);
    // line disabled, nothing reaches the chain
    write_reg(`FE_ADDR_SPI_MUX, 24'h0);
    spi_cs2 = 1'b0;
    spi_clk = 1'b1;
    wait_cycles(1);
    check_value("glb_4094_strobe", 32'(glb_4094_strobe), 32'd0);
    check_value("glb_4094_clk", 32'(glb_4094_clk), 32'd0);
    spi_clk = 1'b0;
    spi_cs2 = 1'b1;
    wait_cycles(1);
    report_test("4094 pass-through", fails_before);

    fails_before = total_failures();
    $display("checks passed: %0d, failed: %0d", pass_count, fails_before);
    if (fails_before == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule
